//--- logic/neuralPkg.sv
`default_nettype none

package neuralPkg;

	localparam int dataWidth = 16;
	localparam int inputCount = 15;
	localparam int nodeCount = 4;
	localparam int nodeLatency = 3;
	localparam int addrWidth = 5;

	// Wide enough to count every evaluation that can be inside the node pipeline.
	localparam int flightWidth = $clog2(nodeLatency + 1);

	typedef logic [dataWidth-1:0] dataWord;
	typedef dataWord [inputCount-1:0] activationArray;
	typedef dataWord [nodeCount-1:0] resultArray;

	// One row of weights per node. Products and sums wrap at 16 bits.
	localparam logic signed [dataWidth-1:0] weightTable [nodeCount][inputCount] = '{
		'{16'sd474, -16'sd361, 16'sd101, -16'sd32, 16'sd1024, -16'sd250, 16'sd409,
			-16'sd85, 16'sd292, 16'sd976, -16'sd631, 16'sd126, -16'sd582, 16'sd117,
			16'sd523},
		'{16'sd212, 16'sd87, -16'sd415, 16'sd330, -16'sd128, 16'sd761, -16'sd54,
			16'sd198, -16'sd903, 16'sd45, 16'sd377, -16'sd266, 16'sd512, -16'sd71,
			16'sd139},
		'{-16'sd97, 16'sd643, 16'sd255, -16'sd710, 16'sd64, 16'sd118, -16'sd333,
			16'sd902, -16'sd12, -16'sd487, 16'sd220, 16'sd391, 16'sd76, -16'sd645,
			16'sd301},
		'{16'sd388, -16'sd29, -16'sd540, 16'sd167, 16'sd813, -16'sd402, 16'sd96,
			-16'sd158, 16'sd705, 16'sd233, -16'sd64, -16'sd919, 16'sd450, 16'sd28,
			-16'sd276}
	};

	localparam logic signed [dataWidth-1:0] biasTable [nodeCount] = '{
		16'sd209,
		16'sd150,
		16'sd77,
		16'sd333
	};

	// Word addresses on the bus.
	localparam logic [addrWidth-1:0] inputBase = addrWidth'(0);
	localparam logic [addrWidth-1:0] controlAddr = addrWidth'(15);
	localparam logic [addrWidth-1:0] statusAddr = addrWidth'(16);
	localparam logic [addrWidth-1:0] outputBase = addrWidth'(17);

	// The last field sits at the low end, so a cast to activationArray puts ai at index i.
	typedef struct packed {
		dataWord a14;
		dataWord a13;
		dataWord a12;
		dataWord a11;
		dataWord a10;
		dataWord a9;
		dataWord a8;
		dataWord a7;
		dataWord a6;
		dataWord a5;
		dataWord a4;
		dataWord a3;
		dataWord a2;
		dataWord a1;
		dataWord a0;
	} activationVector;

	typedef struct packed {
		dataWord n3;
		dataWord n2;
		dataWord n1;
		dataWord n0;
	} layerResult;

endpackage

`default_nettype wire

//--- logic/neuronNode.sv
`default_nettype none

module neuronNode #(
	parameter int nodeIndex = 0
) (
	input logic clk,
	input logic reset,
	input neuralPkg::activationVector activations,
	output logic [neuralPkg::dataWidth-1:0] activation
);

	import neuralPkg::*;

	activationArray inputRegs;
	dataWord products [inputCount];
	dataWord sumNext;
	dataWord sumReg;

	// Stage one samples the inputs every cycle.
	// The valid pipeline in the layer marks which sample belongs to a start.
	always_ff @(posedge clk)
	begin
		if (reset)
			inputRegs <= '0;
		else
			inputRegs <= activationArray'(activations);
	end

	// Only the low 16 bits of each product are kept.
	always_comb
	begin
		for (int i = 0; i < inputCount; i++)
			products[i] = dataWord'(inputRegs[i] * weightTable[nodeIndex][i]);
	end

	always_comb
	begin
		sumNext = dataWord'(biasTable[nodeIndex]);
		for (int i = 0; i < inputCount; i++)
			sumNext = sumNext + products[i];
	end

	// Stage two holds the wrapped sum, stage three the ReLU output.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			sumReg <= sumNext;
			// A set sign bit means a negative sum.
			if (sumReg[dataWidth-1])
				activation <= '0;
			else
				activation <= sumReg;
		end
	end

endmodule

`default_nettype wire

//--- logic/denseLayer.sv
`default_nettype none

module denseLayer (
	input logic clk,
	input logic reset,
	input logic start,
	input neuralPkg::activationVector activations,
	output logic resultValid,
	output neuralPkg::layerResult results
);

	import neuralPkg::*;

	resultArray nodeOutputs;
	logic [nodeLatency-1:0] validPipe;

	generate
		for (genvar n = 0; n < nodeCount; n++)
		begin : gNode
			neuronNode #(
				.nodeIndex(n)
			) node (
				.clk(clk),
				.reset(reset),
				.activations(activations),
				.activation(nodeOutputs[n])
			);
		end
	endgenerate

	// One stage per node stage, so a start comes out together with its outputs.
	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[nodeLatency-2:0], start};
	end

	assign resultValid = validPipe[nodeLatency-1];
	assign results = layerResult'(nodeOutputs);

endmodule

`default_nettype wire

//--- logic/wishboneLayerPort.sv
`default_nettype none

module wishboneLayerPort (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [neuralPkg::addrWidth-1:0] adr,
	input logic [neuralPkg::dataWidth-1:0] writeData,
	output logic [neuralPkg::dataWidth-1:0] readData,
	output logic ack,
	output logic start,
	output neuralPkg::activationVector activations,
	input logic resultValid,
	input neuralPkg::layerResult results
);

	import neuralPkg::*;

	activationArray inputRegs;
	resultArray outputRegs;
	logic request;
	logic [addrWidth-1:0] inputOffset;
	logic [addrWidth-1:0] outputOffset;
	logic [$clog2(inputCount)-1:0] inputIndex;
	logic [$clog2(nodeCount)-1:0] outputIndex;
	logic inputHit;
	logic outputHit;
	dataWord readMux;
	logic done;
	logic [flightWidth-1:0] inFlight;

	// An access counts once. The cycle that carries ack is not a new request.
	assign request = cyc && stb && !ack;

	assign inputOffset = adr - inputBase;
	assign outputOffset = adr - outputBase;
	assign inputIndex = inputOffset[$clog2(inputCount)-1:0];
	assign outputIndex = outputOffset[$clog2(nodeCount)-1:0];
	assign inputHit = inputOffset < addrWidth'(inputCount);
	assign outputHit = outputOffset < addrWidth'(nodeCount);

	// Control and unmapped addresses read as zero.
	always_comb
	begin
		readMux = '0;
		if (inputHit)
			readMux = inputRegs[inputIndex];
		else if (adr == statusAddr)
			readMux = dataWord'(done);
		else if (outputHit)
			readMux = outputRegs[outputIndex];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			start <= 1'b0;
			readData <= '0;
			inputRegs <= '0;
		end
		else
		begin
			ack <= request;
			start <= request && we && adr == controlAddr;
			if (request && !we)
				readData <= readMux;
			if (request && we && inputHit)
				inputRegs[inputIndex] <= writeData;
		end
	end

	assign activations = activationVector'(inputRegs);

	// Done belongs to the newest start, so older results still in flight do not set it.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outputRegs <= '0;
			done <= 1'b0;
			inFlight <= '0;
		end
		else
		begin
			if (resultValid)
				outputRegs <= resultArray'(results);
			case ({start, resultValid})
				2'b10: inFlight <= inFlight + flightWidth'(1);
				2'b01: inFlight <= inFlight - flightWidth'(1);
				default: inFlight <= inFlight;
			endcase
			if (start)
				done <= 1'b0;
			else if (resultValid && inFlight == flightWidth'(1))
				done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/neuralLayerTop.sv
`default_nettype none

module neuralLayerTop (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [neuralPkg::addrWidth-1:0] adr,
	input logic [neuralPkg::dataWidth-1:0] writeData,
	output logic [neuralPkg::dataWidth-1:0] readData,
	output logic ack
);

	import neuralPkg::*;

	logic start;
	logic resultValid;
	activationVector activations;
	layerResult results;

	wishboneLayerPort port (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.writeData(writeData),
		.readData(readData),
		.ack(ack),
		.start(start),
		.activations(activations),
		.resultValid(resultValid),
		.results(results)
	);

	denseLayer layer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.activations(activations),
		.resultValid(resultValid),
		.results(results)
	);

endmodule

`default_nettype wire

//--- testbench/clockGen.sv
`default_nettype none

module clockGen (
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int periodNs = 20;
	localparam int resetCycles = 4;

	initial
	begin
		clk = 1'b0;
		forever
			#(periodNs / 2) clk = ~clk;
	end

	// Reset drops a short time after the fourth rising edge.
	initial
	begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#2;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- testbench/neuralLayer_props.sv
`default_nettype none

module neuralLayerProps (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [neuralPkg::addrWidth-1:0] adr,
	input logic ack,
	input logic start
);

	timeunit 1ns;
	timeprecision 1ps;

	import neuralPkg::*;

	ackSingleCycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
		else $error("ack stayed high for more than one cycle");

	ackNeedsRequest: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(cyc && stb))
		else $error("ack rose without cyc and stb");

	// The request that caused start was sampled one edge earlier.
	startOnControlWrite: assert property (@(posedge clk) disable iff (reset)
		start |-> ack && $past(cyc && stb && we && adr == controlAddr))
		else $error("start pulsed outside an acknowledged control write");

endmodule

`default_nettype wire

//--- testbench/neuralLayerTb.sv
`default_nettype none

module neuralLayerTb;

	timeunit 1ns;
	timeprecision 1ps;

	import neuralPkg::*;

	localparam int evalCount = 50;
	localparam int testCount = evalCount + 14;
	localparam int busCyclesPerTest = 80;
	localparam int watchdogNs = testCount * busCyclesPerTest * 20 + 10000;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [addrWidth-1:0] adr;
	dataWord writeData;
	dataWord readData;
	logic ack;

	int checkCount = 0;
	int mismatchCount = 0;
	int failureCount = 0;
	string nameQueue[$];
	dataWord expectQueue[$];
	dataWord actualQueue[$];
	event queued;

	clockGen clocks (
		.clk(clk),
		.reset(reset)
	);

	neuralLayerTop dut (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.writeData(writeData),
		.readData(readData),
		.ack(ack)
	);

	bind wishboneLayerPort neuralLayerProps props (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.ack(ack),
		.start(start)
	);

	// The exact sum of bias and products, reduced modulo 2^16 only at the end.
	function automatic dataWord nodeSum(int node, activationArray a);
		int acc;
		acc = int'(biasTable[node]);
		for (int i = 0; i < inputCount; i++)
			acc += int'(a[i]) * int'(weightTable[node][i]);
		return dataWord'(acc);
	endfunction

	function automatic resultArray refLayer(activationArray a);
		resultArray r;
		dataWord sum;
		for (int n = 0; n < nodeCount; n++)
		begin
			sum = nodeSum(n, a);
			r[n] = sum[dataWidth-1] ? '0 : sum;
		end
		return r;
	endfunction

	task automatic queueCheck(input string name, input dataWord expected, input dataWord actual);
		nameQueue.push_back(name);
		expectQueue.push_back(expected);
		actualQueue.push_back(actual);
		-> queued;
	endtask

	// One classic cycle. Signals change 2 ns after an edge and ack is sampled there too.
	task automatic busAccess(input logic write, input int address, input dataWord data,
		output dataWord value);
		int waitCycles;
		waitCycles = 0;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addrWidth'(address);
		writeData = data;
		do
		begin
			@(posedge clk);
			#2;
			waitCycles++;
		end while (!ack && waitCycles < 8);
		if (!ack)
		begin
			$display("the slave never acknowledged an access to address %0d", address);
			failureCount++;
		end
		value = readData;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic busWrite(input int address, input dataWord data);
		dataWord unused;
		busAccess(1'b1, address, data, unused);
	endtask

	task automatic busRead(input int address, output dataWord value);
		busAccess(1'b0, address, '0, value);
	endtask

	task automatic loadInputs(input activationArray a);
		for (int i = 0; i < inputCount; i++)
			busWrite(int'(inputBase) + i, a[i]);
	endtask

	task automatic waitDone();
		dataWord status;
		int polls;
		status = '0;
		polls = 0;
		while (status[0] == 1'b0 && polls < 20)
		begin
			busRead(int'(statusAddr), status);
			polls++;
		end
		if (status[0] == 1'b0)
		begin
			$display("the done flag was never set after a start");
			failureCount++;
		end
	endtask

	task automatic checkOutputs(input string name, input resultArray expected);
		dataWord value;
		for (int n = 0; n < nodeCount; n++)
		begin
			busRead(int'(outputBase) + n, value);
			queueCheck($sformatf("%s node %0d", name, n), expected[n], value);
		end
	endtask

	task automatic evaluate(input string name, input activationArray a);
		loadInputs(a);
		busWrite(int'(controlAddr), '0);
		waitDone();
		checkOutputs(name, refLayer(a));
	endtask

	task automatic randomVector(output activationArray a);
		for (int i = 0; i < inputCount; i++)
			a[i] = dataWord'($urandom);
	endtask

	initial
	begin
		string name;
		dataWord expected;
		dataWord actual;
		forever
		begin
			@(queued);
			while (actualQueue.size() > 0)
			begin
				name = nameQueue.pop_front();
				expected = expectQueue.pop_front();
				actual = actualQueue.pop_front();
				checkCount++;
				if (actual !== expected)
				begin
					mismatchCount++;
					$display("error %s: expected %h, actual %h", name, expected, actual);
				end
			end
		end
	end

	initial
	begin
		activationArray vec;
		activationArray second;
		dataWord value;
		dataWord sum;
		logic [nodeCount-1:0] negative;
		logic [nodeCount-1:0] found;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		writeData = '0;
		void'($urandom(32'hd119_5206));
		wait (!reset);
		@(posedge clk);
		#2;

		busRead(int'(statusAddr), value);
		queueCheck("reset status", '0, value);
		checkOutputs("reset", '0);

		randomVector(vec);
		loadInputs(vec);
		for (int i = 0; i < inputCount; i++)
		begin
			busRead(int'(inputBase) + i, value);
			queueCheck($sformatf("readback %0d", i), vec[i], value);
		end

		for (int t = 0; t < evalCount; t++)
		begin
			randomVector(vec);
			evaluate($sformatf("eval %0d", t), vec);
		end

		// Zero inputs leave only the positive biases.
		evaluate("zero inputs", '0);
		found = '0;
		for (int s = 0; s < 1000 && found != '1; s++)
		begin
			randomVector(vec);
			for (int n = 0; n < nodeCount; n++)
			begin
				sum = nodeSum(n, vec);
				negative[n] = sum[dataWidth-1];
			end
			if ((negative & ~found) != '0)
			begin
				evaluate($sformatf("relu %b", negative), vec);
				found = found | negative;
			end
		end
		if (found != '1)
		begin
			$display("no random vector gave a negative sum on every node");
			failureCount++;
		end

		randomVector(vec);
		randomVector(second);
		loadInputs(vec);
		busWrite(int'(controlAddr), '0);
		loadInputs(second);
		busWrite(int'(controlAddr), '0);
		waitDone();
		checkOutputs("back to back", refLayer(second));

		for (int addr = 21; addr < 32; addr++)
		begin
			busWrite(addr, dataWord'($urandom));
			busRead(addr, value);
			queueCheck($sformatf("unmapped read %0d", addr), '0, value);
		end
		for (int i = 0; i < inputCount; i++)
		begin
			busRead(int'(inputBase) + i, value);
			queueCheck($sformatf("input %0d after unmapped writes", i), second[i], value);
		end
		checkOutputs("after unmapped writes", refLayer(second));
		busRead(int'(statusAddr), value);
		queueCheck("status after unmapped writes", 16'd1, value);

		#1;
		$display("checks %0d, mismatches %0d, other failures %0d",
			checkCount, mismatchCount, failureCount);
		if (mismatchCount == 0 && failureCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		#(watchdogNs);
		$display("the watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
logic/neuralPkg.sv
logic/neuronNode.sv
logic/denseLayer.sv
logic/wishboneLayerPort.sv
logic/neuralLayerTop.sv
testbench/clockGen.sv
testbench/neuralLayer_props.sv
testbench/neuralLayerTb.sv

//--- run.sh
#!/bin/sh
# Builds the simulation with Verilator, runs it and looks for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module neuralLayerTb -f sources.f

output=$(./obj_dir/VneuralLayerTb 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1
